// File: src/ray_pkg.sv
package ray_pkg;

  // ray store geometry
  localparam int RAY_ID_W  = 9;
  localparam int RAY_COUNT = 1 << RAY_ID_W;

  // unsigned Q4.12 fixed point used for colour and reflectance
  localparam int FX_W      = 16;
  localparam int FX_FRAC   = 12;
  localparam int FX_PROD_W = 2 * FX_W;  // full width of a product before the shift

  typedef logic [RAY_ID_W-1:0] ray_id_t;
  typedef logic [FX_W-1:0]     color_t;
  typedef logic [FX_PROD_W-1:0] fx_prod_t;

  localparam color_t FX_ONE = color_t'(1 << FX_FRAC);  // 1.0 is 4096
  localparam color_t FX_MAX = '1;                       // saturation ceiling

  // one store word, accumulated colour next to the running mask
  typedef struct packed {
    color_t b;
    color_t m;
  } bm_entry_t;

  // shading record coming in for one bounce
  typedef struct packed {
    ray_id_t ray_id;
    color_t  direct;
    color_t  spec;
    logic    last;
  } shade_t;

  // record handed downstream once a bounce has been folded in
  typedef struct packed {
    ray_id_t ray_id;
    color_t  color;  // new B
    color_t  mask;   // new M
    logic    last;
  } raydone_t;

  localparam int BM_ENTRY_W = $bits(bm_entry_t);
  localparam int SHADE_W    = $bits(shade_t);
  localparam int RAYDONE_W  = $bits(raydone_t);

endpackage

// File: src/bm_result_if.sv
`timescale 1ns/100ps

// ray-done records from the update stage into the output queue, with the
// pop strobe going back so the update stage can return credits
interface bm_result_if;

  logic              push;  // one record per cycle at most
  ray_pkg::raydone_t rec;
  logic              pop;   // one strobe per record leaving at the top ports

  modport producer (
    output push,
    output rec,
    input  pop
  );

  modport consumer (
    input  push,
    input  rec,
    output pop
  );

endinterface

// File: src/bm_store.sv
`timescale 1ns/100ps

module bm_store (
  input  logic                clk,
  input  ray_pkg::ray_id_t    rd_addr,
  input  logic                wr_en,
  input  ray_pkg::ray_id_t    wr_addr,
  input  ray_pkg::bm_entry_t  wr_data,
  output ray_pkg::bm_entry_t  rd_data
);

  // one B/M pair per ray
  ray_pkg::bm_entry_t mem [ray_pkg::RAY_COUNT];

  // read is registered, data shows up the cycle after the address
  // a read and write to one address in the same cycle returns the old word
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

// File: src/delay_line.sv
`timescale 1ns/100ps

module delay_line #(
  parameter int LAT   = 1,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] stage_q [LAT];

  always_ff @(posedge clk) begin
    if (reset) begin
      // cleared so that any valid bit carried along starts low
      for (int i = 0; i < LAT; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_in;
      for (int i = 1; i < LAT; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_out = stage_q[LAT-1];

endmodule

// File: src/fx_mult.sv
`timescale 1ns/100ps

module fx_mult #(
  parameter int LAT = 3
) (
  input  logic            clk,
  input  logic            reset,
  input  ray_pkg::color_t a,
  input  ray_pkg::color_t b,
  output ray_pkg::color_t p
);

  // drop the low fraction bits and clamp anything that no longer fits Q4.12
  function automatic ray_pkg::color_t saturate(input ray_pkg::fx_prod_t full);
    ray_pkg::fx_prod_t shifted;
    shifted = full >> ray_pkg::FX_FRAC;
    if (|shifted[ray_pkg::FX_PROD_W-1:ray_pkg::FX_W]) begin
      return ray_pkg::FX_MAX;
    end
    return shifted[ray_pkg::FX_W-1:0];
  endfunction

  generate
    if (LAT == 1) begin : g_single
      ray_pkg::color_t p_q;

      // everything in one stage
      always_ff @(posedge clk) begin
        if (reset) p_q <= '0;
        else       p_q <= saturate(ray_pkg::fx_prod_t'(a) * ray_pkg::fx_prod_t'(b));
      end

      assign p = p_q;
    end else begin : g_multi
      ray_pkg::fx_prod_t prod_q;            // raw product, first stage
      ray_pkg::color_t   res_q [LAT-1];     // shift/clamp, then plain delay

      always_ff @(posedge clk) begin
        if (reset) begin
          prod_q <= '0;
          for (int i = 0; i < LAT - 1; i++) begin
            res_q[i] <= '0;
          end
        end else begin
          prod_q   <= ray_pkg::fx_prod_t'(a) * ray_pkg::fx_prod_t'(b);
          res_q[0] <= saturate(prod_q);
          for (int i = 1; i < LAT - 1; i++) begin
            res_q[i] <= res_q[i-1];
          end
        end
      end

      assign p = res_q[LAT-2];
    end
  endgenerate

endmodule

// File: src/bm_update.sv
`timescale 1ns/100ps

module bm_update #(
  parameter int MULT_LAT    = 3,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic               clk,
  input  logic               reset,

  input  logic               shade_valid,
  input  ray_pkg::shade_t    shade_in,
  output logic               shade_ready,

  input  logic               init_valid,
  input  ray_pkg::ray_id_t   init_ray_id,
  output logic               init_ready,

  output ray_pkg::ray_id_t   rd_addr,
  input  ray_pkg::bm_entry_t rd_data,
  output logic               wr_en,
  output ray_pkg::ray_id_t   wr_addr,
  output ray_pkg::bm_entry_t wr_data,

  bm_result_if.producer      result
);

  localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

  // side data lined up with the store read, one cycle after acceptance
  typedef struct packed {
    ray_pkg::color_t  direct;
    ray_pkg::color_t  spec;
    ray_pkg::ray_id_t ray_id;
    logic             last;
    logic             valid;
  } side_read_t;

  // side data riding beside the multipliers
  typedef struct packed {
    ray_pkg::color_t  b;
    ray_pkg::ray_id_t ray_id;
    logic             last;
    logic             valid;
  } side_mult_t;

  logic                  shade_fire;
  logic                  init_fire;
  logic [CREDIT_W-1:0]   credits;
  side_read_t            rd_side_in, rd_side_q;
  side_mult_t            mult_side_in, mult_side_q;
  ray_pkg::color_t       m_direct;   // M times direct
  ray_pkg::color_t       m_spec;     // M times spec, the new mask
  logic [ray_pkg::FX_W:0] sum;       // one extra bit to catch overflow
  ray_pkg::color_t       new_color;
  logic                  wb_valid;

  // a shade is only taken if its record is sure to find room in the queue
  assign shade_ready = (credits != '0);
  assign shade_fire  = shade_valid & shade_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(QUEUE_DEPTH);
    end else begin
      unique case ({shade_fire, result.pop})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // none or both at once
      endcase
    end
  end

  assign rd_addr = shade_in.ray_id;

  always_comb begin
    rd_side_in.direct = shade_in.direct;
    rd_side_in.spec   = shade_in.spec;
    rd_side_in.ray_id = shade_in.ray_id;
    rd_side_in.last   = shade_in.last;
    rd_side_in.valid  = shade_fire;
  end

  delay_line #(.LAT(1), .WIDTH($bits(side_read_t))) read_align (
    .clk      (clk),
    .reset    (reset),
    .data_in  (rd_side_in),
    .data_out (rd_side_q)
  );

  fx_mult #(.LAT(MULT_LAT)) mult_direct (
    .clk   (clk),
    .reset (reset),
    .a     (rd_data.m),
    .b     (rd_side_q.direct),
    .p     (m_direct)
  );

  fx_mult #(.LAT(MULT_LAT)) mult_spec (
    .clk   (clk),
    .reset (reset),
    .a     (rd_data.m),
    .b     (rd_side_q.spec),
    .p     (m_spec)
  );

  always_comb begin
    mult_side_in.b      = rd_data.b;
    mult_side_in.ray_id = rd_side_q.ray_id;
    mult_side_in.last   = rd_side_q.last;
    mult_side_in.valid  = rd_side_q.valid;
  end

  delay_line #(.LAT(MULT_LAT), .WIDTH($bits(side_mult_t))) mult_align (
    .clk      (clk),
    .reset    (reset),
    .data_in  (mult_side_in),
    .data_out (mult_side_q)
  );

  // B plus M times direct, clamped at the top of the range
  assign sum       = {1'b0, mult_side_q.b} + {1'b0, m_direct};
  assign new_color = sum[ray_pkg::FX_W] ? ray_pkg::FX_MAX : sum[ray_pkg::FX_W-1:0];
  assign wb_valid  = mult_side_q.valid;

  assign result.push        = wb_valid;
  assign result.rec.ray_id  = mult_side_q.ray_id;
  assign result.rec.color   = new_color;
  assign result.rec.mask    = m_spec;
  assign result.rec.last    = mult_side_q.last;

  // write-back owns the write port, an init waits for a free cycle
  assign init_ready = ~wb_valid;
  assign init_fire  = init_valid & init_ready;
  assign wr_en      = wb_valid | init_fire;

  always_comb begin
    if (wb_valid) begin
      wr_addr   = mult_side_q.ray_id;
      wr_data.b = new_color;
      wr_data.m = m_spec;
    end else begin
      wr_addr   = init_ray_id;
      wr_data.b = '0;              // nothing gathered yet
      wr_data.m = ray_pkg::FX_ONE; // full reflectance
    end
  end

endmodule

// File: src/raydone_queue.sv
`timescale 1ns/100ps

module raydone_queue #(
  parameter int DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              done_ready,
  output logic              done_valid,
  output ray_pkg::raydone_t done_rec,
  bm_result_if.consumer     result
);

  localparam int PTR_W   = $clog2(DEPTH);
  localparam int COUNT_W = $clog2(DEPTH + 1);

  ray_pkg::raydone_t   mem [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [COUNT_W-1:0]  count;
  logic                pop;

  // head of the queue goes straight out
  assign done_valid = (count != '0);
  assign done_rec   = mem[rd_ptr];
  assign pop        = done_valid & done_ready;
  assign result.pop = pop;

  // storage only, credits upstream keep pushes away from a full queue
  always_ff @(posedge clk) begin
    if (result.push) begin
      mem[wr_ptr] <= result.rec;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (result.push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
      if (pop)         rd_ptr <= rd_ptr + 1'b1;
      unique case ({result.push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/ray_shade_top.sv
`timescale 1ns/100ps

module ray_shade_top #(
  parameter int MULT_LAT    = 3,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic             clk,
  input  logic             reset,

  input  logic             shade_valid,
  input  ray_pkg::ray_id_t shade_ray_id,
  input  ray_pkg::color_t  shade_direct,
  input  ray_pkg::color_t  shade_spec,
  input  logic             shade_last,
  output logic             shade_ready,

  input  logic             init_valid,
  input  ray_pkg::ray_id_t init_ray_id,
  output logic             init_ready,

  output logic             done_valid,
  output ray_pkg::ray_id_t done_ray_id,
  output ray_pkg::color_t  done_color,
  output ray_pkg::color_t  done_mask,
  output logic             done_last,
  input  logic             done_ready
);

  ray_pkg::shade_t    shade_in;
  ray_pkg::raydone_t  done_rec;
  ray_pkg::ray_id_t   rd_addr;
  ray_pkg::ray_id_t   wr_addr;
  ray_pkg::bm_entry_t rd_data;
  ray_pkg::bm_entry_t wr_data;
  logic               wr_en;

  bm_result_if result_bus ();

  assign shade_in = '{ray_id: shade_ray_id, direct: shade_direct,
                      spec: shade_spec, last: shade_last};

  bm_update #(.MULT_LAT(MULT_LAT), .QUEUE_DEPTH(QUEUE_DEPTH)) bm_update_inst (
    .clk         (clk),
    .reset       (reset),
    .shade_valid (shade_valid),
    .shade_in    (shade_in),
    .shade_ready (shade_ready),
    .init_valid  (init_valid),
    .init_ray_id (init_ray_id),
    .init_ready  (init_ready),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .result      (result_bus.producer)
  );

  bm_store bm_store_inst (
    .clk     (clk),
    .rd_addr (rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  raydone_queue #(.DEPTH(QUEUE_DEPTH)) raydone_queue_inst (
    .clk        (clk),
    .reset      (reset),
    .done_ready (done_ready),
    .done_valid (done_valid),
    .done_rec   (done_rec),
    .result     (result_bus.consumer)
  );

  // flatten the head record onto the output ports
  assign done_ray_id = done_rec.ray_id;
  assign done_color  = done_rec.color;
  assign done_mask   = done_rec.mask;
  assign done_last   = done_rec.last;

endmodule

// File: verification/tb_ray_shade_top.sv
`timescale 1ns/100ps

module tb_ray_shade_top;

  localparam int MULT_LAT    = 3;
  localparam int QUEUE_DEPTH = 8;
  localparam int TIMEOUT     = 200;  // cycles allowed for any single wait

  // one stimulus row, either an init or a shade for one ray
  typedef struct packed {
    logic             is_init;
    logic             drain;   // let all earlier records leave before this row
    ray_pkg::ray_id_t ray_id;
    ray_pkg::color_t  direct;
    ray_pkg::color_t  spec;
    logic             last;
  } row_t;

  logic             clk = 1'b0;
  logic             reset;
  logic             shade_valid;
  ray_pkg::ray_id_t shade_ray_id;
  ray_pkg::color_t  shade_direct;
  ray_pkg::color_t  shade_spec;
  logic             shade_last;
  logic             shade_ready;
  logic             init_valid;
  ray_pkg::ray_id_t init_ray_id;
  logic             init_ready;
  logic             done_valid;
  ray_pkg::ray_id_t done_ray_id;
  ray_pkg::color_t  done_color;
  ray_pkg::color_t  done_mask;
  logic             done_last;
  logic             done_ready;

  row_t              rows [$];
  ray_pkg::raydone_t exp_q [$];   // records still owed by the DUT, oldest first
  ray_pkg::raydone_t head;
  ray_pkg::color_t   model_b [ray_pkg::RAY_COUNT];
  ray_pkg::color_t   model_m [ray_pkg::RAY_COUNT];
  logic [31:0]       data_rnd;
  logic [31:0]       ready_rnd;
  int                ready_mode = 0;  // 0 random, 1 held low, 2 held high
  int                waited;

  ray_shade_top #(.MULT_LAT(MULT_LAT), .QUEUE_DEPTH(QUEUE_DEPTH)) ray_shade_top_inst (
    .clk          (clk),
    .reset        (reset),
    .shade_valid  (shade_valid),
    .shade_ray_id (shade_ray_id),
    .shade_direct (shade_direct),
    .shade_spec   (shade_spec),
    .shade_last   (shade_last),
    .shade_ready  (shade_ready),
    .init_valid   (init_valid),
    .init_ray_id  (init_ray_id),
    .init_ready   (init_ready),
    .done_valid   (done_valid),
    .done_ray_id  (done_ray_id),
    .done_color   (done_color),
    .done_mask    (done_mask),
    .done_last    (done_last),
    .done_ready   (done_ready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Q4.12 product, anything at 16.0 or above clamps to the top code
  function automatic ray_pkg::color_t fx_mul(input ray_pkg::color_t a, input ray_pkg::color_t b);
    logic [31:0] prod;
    prod = {16'h0000, a} * {16'h0000, b};
    if (prod >= 32'h1000_0000) return 16'hffff;
    return prod[27:12];
  endfunction

  function automatic ray_pkg::color_t fx_add(input ray_pkg::color_t a, input ray_pkg::color_t b);
    logic [16:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    if (sum > 17'h0ffff) return 16'hffff;
    return sum[15:0];
  endfunction

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    stop_run();
  endtask

  task automatic check_ray_id(input string name, input ray_pkg::ray_id_t got,
                              input ray_pkg::ray_id_t want);
    if (got !== want) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, want);
      stop_run();
    end
  endtask

  task automatic check_color(input string name, input ray_pkg::color_t got,
                             input ray_pkg::color_t want);
    if (got !== want) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, want);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, want);
      stop_run();
    end
  endtask

  task automatic add_row(input logic is_init, input logic drain, input ray_pkg::ray_id_t id,
                         input ray_pkg::color_t direct, input ray_pkg::color_t spec,
                         input logic last);
    rows.push_back('{is_init: is_init, drain: drain, ray_id: id, direct: direct,
                     spec: spec, last: last});
  endtask

  // entered and left 10 ns after a rising edge, like every driving task
  task automatic issue_init(input ray_pkg::ray_id_t id);
    int n;
    n = 0;
    init_valid  = 1'b1;
    init_ray_id = id;
    @(negedge clk);
    while (init_ready !== 1'b1) begin
      n++;
      if (n > TIMEOUT) report_timeout("init_ready");
      @(negedge clk);
    end
    model_b[id] = '0;
    model_m[id] = 16'h1000;  // a fresh ray reflects everything
    @(posedge clk);
    #10;
    init_valid = 1'b0;
  endtask

  task automatic send_shade(input ray_pkg::ray_id_t id, input ray_pkg::color_t direct,
                            input ray_pkg::color_t spec, input logic last, output int n);
    ray_pkg::raydone_t rec;
    n = 0;
    shade_valid  = 1'b1;
    shade_ray_id = id;
    shade_direct = direct;
    shade_spec   = spec;
    shade_last   = last;
    @(negedge clk);
    while (shade_ready !== 1'b1) begin
      n++;
      if (n > TIMEOUT) report_timeout("shade_ready");
      @(negedge clk);
    end
    rec.ray_id  = id;
    rec.color   = fx_add(model_b[id], fx_mul(model_m[id], direct));
    rec.mask    = fx_mul(model_m[id], spec);
    rec.last    = last;
    model_b[id] = rec.color;
    model_m[id] = rec.mask;
    exp_q.push_back(rec);
    @(posedge clk);
    #10;
    shade_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n > TIMEOUT) report_timeout("the expected records to leave the queue");
      @(posedge clk);
      #10;
    end
  endtask

  // done_ready changes only 10 ns after a rising edge
  initial begin
    done_ready = 1'b0;
    ready_rnd  = 32'h6410_a1c9;
    forever begin
      @(posedge clk);
      #10;
      ready_rnd = xorshift(ready_rnd);
      case (ready_mode)
        1:       done_ready = 1'b0;
        2:       done_ready = 1'b1;
        default: done_ready = (ready_rnd[1:0] != 2'b00);
      endcase
    end
  end

  // valid and ready seen at the falling edge mean a transfer on the next rising edge
  always @(negedge clk) begin
    if (reset === 1'b0 && done_valid === 1'b1 && done_ready === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("ray %0d came out although no record was expected", done_ray_id);
        stop_run();
      end
      head = exp_q.pop_front();
      check_ray_id("done_ray_id", done_ray_id, head.ray_id);
      check_color("done_color", done_color, head.color);
      check_color("done_mask", done_mask, head.mask);
      check_flag("done_last", done_last, head.last);
    end
  end

  initial begin
    reset        = 1'b1;
    shade_valid  = 1'b0;
    shade_ray_id = '0;
    shade_direct = '0;
    shade_spec   = '0;
    shade_last   = 1'b0;
    init_valid   = 1'b0;
    init_ray_id  = '0;
    data_rnd     = 32'h6410_a1c9;

    add_row(1'b1, 1'b0, 9'd5, 16'h0000, 16'h0000, 1'b0);
    add_row(1'b0, 1'b0, 9'd5, 16'h0c00, 16'h0800, 1'b1);  // color is direct, mask is spec
    add_row(1'b1, 1'b0, 9'd7, 16'h0000, 16'h0000, 1'b0);
    add_row(1'b0, 1'b0, 9'd7, 16'h1000, 16'h0c00, 1'b0);
    add_row(1'b0, 1'b1, 9'd7, 16'h0800, 16'h0a00, 1'b0);
    add_row(1'b0, 1'b1, 9'd7, 16'h2000, 16'h1000, 1'b1);
    // mask grows to 4.0, then the add and the mask product both overflow
    add_row(1'b1, 1'b0, 9'd3, 16'h0000, 16'h0000, 1'b0);
    add_row(1'b0, 1'b0, 9'd3, 16'hffff, 16'h4000, 1'b0);
    add_row(1'b0, 1'b1, 9'd3, 16'h1000, 16'h8000, 1'b1);
    for (int i = 0; i < 20; i++) begin
      add_row(1'b1, 1'b0, ray_pkg::ray_id_t'(100 + i), 16'h0000, 16'h0000, 1'b0);
    end
    for (int i = 0; i < 20; i++) begin
      data_rnd = xorshift(data_rnd);
      add_row(1'b0, 1'b0, ray_pkg::ray_id_t'(100 + i), {2'b00, data_rnd[13:0]},
              {3'b000, data_rnd[28:16]}, data_rnd[31]);
    end
    add_row(1'b1, 1'b1, 9'd7, 16'h0000, 16'h0000, 1'b0);  // ray 7 starts over
    add_row(1'b0, 1'b0, 9'd7, 16'h0123, 16'h0456, 1'b1);

    repeat (2) @(posedge clk);
    #10;
    reset = 1'b0;
    @(negedge clk);
    check_flag("done_valid", done_valid, 1'b0);
    check_flag("shade_ready", shade_ready, 1'b1);
    check_flag("init_ready", init_ready, 1'b1);
    @(posedge clk);
    #10;

    foreach (rows[i]) begin
      if (rows[i].drain) wait_drain();
      if (rows[i].is_init) issue_init(rows[i].ray_id);
      else send_shade(rows[i].ray_id, rows[i].direct, rows[i].spec, rows[i].last, waited);
    end

    // output stalled, so the credits run out after exactly QUEUE_DEPTH shades
    for (int k = 0; k < QUEUE_DEPTH; k++) begin
      issue_init(ray_pkg::ray_id_t'(200 + k));
    end
    wait_drain();
    ready_mode = 1;
    @(posedge clk);
    #10;
    @(posedge clk);
    #10;
    for (int k = 0; k < QUEUE_DEPTH; k++) begin
      send_shade(ray_pkg::ray_id_t'(200 + k), ray_pkg::color_t'(16'h0400 + 16'h0111 * k),
                 16'h0800, 1'b1, waited);
      if (waited != 0) begin
        $display("shade_ready fell before %0d shades were accepted", QUEUE_DEPTH);
        stop_run();
      end
    end
    repeat (4) begin
      @(negedge clk);
      check_flag("shade_ready", shade_ready, 1'b0);
    end
    @(posedge clk);
    #10;
    ready_mode = 0;
    wait_drain();

    // any record beyond the expected ones is caught while the output is open
    ready_mode = 2;
    repeat (20) @(posedge clk);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: filelist.f
src/ray_pkg.sv
src/bm_result_if.sv
src/bm_store.sv
src/delay_line.sv
src/fx_mult.sv
src/bm_update.sv
src/raydone_queue.sv
src/ray_shade_top.sv
verification/tb_ray_shade_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
  --top-module tb_ray_shade_top -o sim_ray_shade

./obj_dir/sim_ray_shade > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
